// ==== verilog/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// a jump here ends the program
`define RV_HALT_PC 32'hffff_fffc

// store target of the LED word register
`define RV_LED_ADDR 32'h0000_4000

// first address past RAM
// loads at or above it read zero, stores there are dropped
`define RV_RAM_LIMIT 32'h0000_4000

// architectural integer registers
`define RV_NUM_REGS 32

`endif

// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

	// major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011
	} opcode_e;

	// ALU operation select
	typedef enum logic [2:0] {
		ADD_SUB = 3'b000,
		SLL     = 3'b001,
		SLT     = 3'b010,
		SLTU    = 3'b011,
		XOR     = 3'b100,
		SRL_SRA = 3'b101,
		OR      = 3'b110,
		AND     = 3'b111
	} funct3_e;

	// branch conditions share the funct3 field
	localparam funct3_e BEQ  = ADD_SUB;
	localparam funct3_e BNE  = SLL;
	localparam funct3_e BLT  = XOR;
	localparam funct3_e BGE  = SRL_SRA;
	localparam funct3_e BLTU = OR;
	localparam funct3_e BGEU = AND;

	typedef struct packed {
		opcode_e     opcode;
		funct3_e     funct3;
		// selects sub and sra
		logic        f7_alt;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] imm;
		logic        is_load;
		logic        is_store;
		logic        is_jump;
		logic        is_branch;
		logic        writes_rd;
		logic        uses_rs2;
	} decoded_inst_t;

endpackage

// ==== verilog/rv_bus_pkg.sv ====
package rv_bus_pkg;

	// one state per instruction phase, plus the stop state
	typedef enum logic [2:0] {
		S_IF   = 3'd0,
		S_ID   = 3'd1,
		S_EX   = 3'd2,
		S_MEM  = 3'd3,
		S_WB   = 3'd4,
		S_HALT = 3'd5
	} core_state_e;

	// Wishbone classic, master to slave
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [31:0] adr;
		logic [31:0] dat;
		logic [3:0]  sel;
	} wb_req_t;

	// slave to master
	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

endpackage

// ==== verilog/inst_decode.sv ====
module inst_decode (
	input  logic [31:0]               inst,
	output rv_isa_pkg::decoded_inst_t dec
);
	import rv_isa_pkg::*;

	opcode_e     opcode;
	logic        fmt_i;
	logic        fmt_s;
	logic        fmt_b;
	logic        fmt_u;
	logic        fmt_j;
	logic        fmt_r;
	logic [31:0] imm;

	assign opcode = opcode_e'(inst[6:0]);

	// instruction format from the opcode
	assign fmt_i = (opcode == JALR) || (opcode == LOAD) || (opcode == OP_IMM);
	assign fmt_s = (opcode == STORE);
	assign fmt_b = (opcode == BRANCH);
	assign fmt_u = (opcode == LUI) || (opcode == AUIPC);
	assign fmt_j = (opcode == JAL);
	assign fmt_r = (opcode == OP);

	// sign-extended immediate per format
	always_comb
	begin
		if (fmt_i)
			imm = {{20{inst[31]}}, inst[31:20]};
		else if (fmt_s)
			imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		else if (fmt_b)
			imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
		else if (fmt_u)
			imm = {inst[31:12], 12'd0};
		else if (fmt_j)
			imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
		else
			imm = 32'd0;
	end

	always_comb
	begin
		dec.opcode = opcode;
		dec.funct3 = funct3_e'(inst[14:12]);
		dec.rd = inst[11:7];
		dec.rs1 = inst[19:15];
		dec.rs2 = inst[24:20];
		dec.imm = imm;
		// bit 30 is an immediate bit for everything but OP and the I-type shifts
		dec.f7_alt = inst[30] && (fmt_r || ((opcode == OP_IMM) && (dec.funct3 == SRL_SRA)));
		dec.is_load = (opcode == LOAD);
		dec.is_store = fmt_s;
		dec.is_jump = fmt_j || (opcode == JALR);
		dec.is_branch = fmt_b;
		// unknown opcodes match no format and so write nothing
		dec.writes_rd = fmt_i || fmt_u || fmt_j || fmt_r;
		dec.uses_rs2 = fmt_r || fmt_s || fmt_b;
	end

endmodule

// ==== verilog/alu.sv ====
module alu (
	input  rv_isa_pkg::decoded_inst_t dec,
	input  logic [31:0]               rs1_val,
	input  logic [31:0]               rs2_val,
	output logic [31:0]               result,
	output logic                      taken
);
	import rv_isa_pkg::*;

	logic [31:0] op_b;
	logic [4:0]  shamt;
	logic [31:0] sra_res;
	logic        eq;
	logic        lt_s;
	logic        lt_u;
	logic        cond;

	// stores carry rs2 as data, not as an operand
	assign op_b = (dec.uses_rs2 && !dec.is_store) ? rs2_val : dec.imm;
	assign shamt = op_b[4:0];
	assign sra_res = $signed(rs1_val) >>> shamt;

	assign eq = (rs1_val == op_b);
	assign lt_s = ($signed(rs1_val) < $signed(op_b));
	assign lt_u = (rs1_val < op_b);

	always_comb
	begin
		if (dec.is_load || dec.is_store)
			result = rs1_val + dec.imm;
		else
		begin
			case (dec.funct3)
				ADD_SUB: result = dec.f7_alt ? (rs1_val - op_b) : (rs1_val + op_b);
				SLL:     result = rs1_val << shamt;
				SLT:     result = {31'd0, lt_s};
				SLTU:    result = {31'd0, lt_u};
				XOR:     result = rs1_val ^ op_b;
				SRL_SRA: result = dec.f7_alt ? sra_res : (rs1_val >> shamt);
				OR:      result = rs1_val | op_b;
				AND:     result = rs1_val & op_b;
				default: result = 32'd0;
			endcase
		end
	end

	// branch compare
	always_comb
	begin
		case (dec.funct3)
			BEQ:     cond = eq;
			BNE:     cond = !eq;
			BLT:     cond = lt_s;
			BGE:     cond = !lt_s;
			BLTU:    cond = lt_u;
			BGEU:    cond = !lt_u;
			default: cond = 1'b0;
		endcase
	end

	assign taken = dec.is_branch && cond;

endmodule

// ==== verilog/reg_file.sv ====
`include "rv_defs.svh"

module reg_file (
	input  logic        cpu_clk,
	input  logic        rst,
	input  logic [4:0]  rs1_addr,
	input  logic [4:0]  rs2_addr,
	output logic [31:0] rs1_val,
	output logic [31:0] rs2_val,
	input  logic        we,
	input  logic [4:0]  rd_addr,
	input  logic [31:0] rd_val
);

	// x0 has no storage
	logic [31:0] regs [1:`RV_NUM_REGS-1];

	assign rs1_val = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
	assign rs2_val = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

	always_ff @(posedge cpu_clk)
	begin
		if (rst)
		begin
			for (int i = 1; i < `RV_NUM_REGS; i++)
				regs[i] <= 32'd0;
		end
		else if (we && (rd_addr != 5'd0))
			regs[rd_addr] <= rd_val;
	end

endmodule

// ==== verilog/core_control.sv ====
`include "rv_defs.svh"

module core_control (
	input  logic                      cpu_clk,
	input  logic                      rst,
	output rv_bus_pkg::wb_req_t       wb_req,
	input  rv_bus_pkg::wb_rsp_t       wb_rsp,
	output logic [31:0]               inst,
	input  rv_isa_pkg::decoded_inst_t dec,
	input  logic [31:0]               rs1_val,
	input  logic [31:0]               rs2_val,
	output logic [31:0]               op_a,
	output logic [31:0]               op_b,
	input  logic [31:0]               alu_result,
	input  logic                      taken,
	output logic                      rf_we,
	output logic [4:0]                rf_rd,
	output logic [31:0]               rf_wdata,
	output logic [31:0]               led_word,
	output logic                      halted
);
	import rv_isa_pkg::*;
	import rv_bus_pkg::*;

	core_state_e state;
	logic [31:0] pc;
	logic [31:0] pc_plus4;
	logic [31:0] pc_next;
	logic [31:0] ex_result;
	logic        ex_taken;
	logic [31:0] load_data;
	logic        bus_done;
	logic        ram_access;

	// full-word request, held until ack
	function automatic wb_req_t bus_start(input logic [31:0] adr, input logic we,
		input logic [31:0] dat);
		wb_req_t r;
		r.cyc = 1'b1;
		r.stb = 1'b1;
		r.we = we;
		r.adr = adr;
		r.dat = dat;
		r.sel = 4'hf;
		return r;
	endfunction

	assign pc_plus4 = pc + 32'd4;
	assign bus_done = wb_req.cyc && wb_rsp.ack;

	// only RAM addresses go out on the bus
	assign ram_access = (dec.is_load || dec.is_store) && (alu_result < `RV_RAM_LIMIT);

	always_comb
	begin
		if (dec.opcode == JALR)
			pc_next = {ex_result[31:1], 1'b0};
		else if ((dec.opcode == JAL) || ex_taken)
			pc_next = pc + dec.imm;
		else
			pc_next = pc_plus4;
	end

	// write-back source
	always_comb
	begin
		if (dec.opcode == LUI)
			rf_wdata = dec.imm;
		else if (dec.opcode == AUIPC)
			rf_wdata = pc + dec.imm;
		else if (dec.is_jump)
			rf_wdata = pc_plus4;
		else if (dec.is_load)
			rf_wdata = load_data;
		else
			rf_wdata = ex_result;
	end

	assign rf_we = (state == S_WB) && dec.writes_rd;
	assign rf_rd = dec.rd;
	assign halted = (state == S_HALT);

	always_ff @(posedge cpu_clk)
	begin
		if (rst)
		begin
			state <= S_IF;
			pc <= `RV_RESET_PC;
			wb_req <= '0;
			led_word <= 32'd0;
		end
		else
		begin
			case (state)
				S_IF:
				begin
					if (bus_done)
					begin
						wb_req <= '0;
						state <= S_ID;
					end
					// first fetch after reset
					else if (!wb_req.cyc)
						wb_req <= bus_start(pc, 1'b0, 32'd0);
				end
				S_ID:
					state <= S_EX;
				S_EX:
				begin
					if (ram_access)
						wb_req <= bus_start(alu_result, dec.is_store, op_b);
					state <= S_MEM;
				end
				S_MEM:
				begin
					if (wb_req.cyc)
					begin
						if (wb_rsp.ack)
						begin
							wb_req <= '0;
							state <= S_WB;
						end
					end
					else
					begin
						if (dec.is_store && (ex_result == `RV_LED_ADDR))
							led_word <= op_b;
						state <= S_WB;
					end
				end
				S_WB:
				begin
					pc <= pc_next;
					if (pc_next == `RV_HALT_PC)
						state <= S_HALT;
					else
					begin
						// fetch overlaps the state change
						wb_req <= bus_start(pc_next, 1'b0, 32'd0);
						state <= S_IF;
					end
				end
				S_HALT:
					state <= S_HALT;
				default:
					state <= S_IF;
			endcase
		end
	end

	// stage registers
	always_ff @(posedge cpu_clk)
	begin
		if ((state == S_IF) && bus_done)
			inst <= wb_rsp.dat;
		if (state == S_ID)
		begin
			op_a <= rs1_val;
			op_b <= rs2_val;
		end
		if (state == S_EX)
		begin
			ex_result <= alu_result;
			ex_taken <= taken;
		end
		// loads outside RAM read zero
		if (state == S_MEM)
			load_data <= wb_req.cyc ? wb_rsp.dat : 32'd0;
	end

endmodule

// ==== verilog/rv_core_top.sv ====
module rv_core_top (
	input  logic                cpu_clk,
	input  logic                rst,
	output rv_bus_pkg::wb_req_t wb_req,
	input  rv_bus_pkg::wb_rsp_t wb_rsp,
	output logic [31:0]         led_word,
	output logic                halted
);
	import rv_isa_pkg::*;

	decoded_inst_t dec;
	logic [31:0]   inst;
	logic [31:0]   rs1_val;
	logic [31:0]   rs2_val;
	logic [31:0]   op_a;
	logic [31:0]   op_b;
	logic [31:0]   alu_result;
	logic          taken;
	logic          rf_we;
	logic [4:0]    rf_rd;
	logic [31:0]   rf_wdata;

	core_control u_core_control (
		.cpu_clk    (cpu_clk),
		.rst        (rst),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.inst       (inst),
		.dec        (dec),
		.rs1_val    (rs1_val),
		.rs2_val    (rs2_val),
		.op_a       (op_a),
		.op_b       (op_b),
		.alu_result (alu_result),
		.taken      (taken),
		.rf_we      (rf_we),
		.rf_rd      (rf_rd),
		.rf_wdata   (rf_wdata),
		.led_word   (led_word),
		.halted     (halted)
	);

	inst_decode u_inst_decode (
		.inst (inst),
		.dec  (dec)
	);

	// operands come from the registers latched in ID
	alu u_alu (
		.dec     (dec),
		.rs1_val (op_a),
		.rs2_val (op_b),
		.result  (alu_result),
		.taken   (taken)
	);

	reg_file u_reg_file (
		.cpu_clk  (cpu_clk),
		.rst      (rst),
		.rs1_addr (dec.rs1),
		.rs2_addr (dec.rs2),
		.rs1_val  (rs1_val),
		.rs2_val  (rs2_val),
		.we       (rf_we),
		.rd_addr  (rf_rd),
		.rd_val   (rf_wdata)
	);

endmodule

// ==== verification/rv_core_properties.sv ====
module rv_core_properties (
	input logic                cpu_clk,
	input logic                rst,
	input rv_bus_pkg::wb_req_t wb_req,
	input rv_bus_pkg::wb_rsp_t wb_rsp,
	input logic                halted
);
	timeunit 1ns;
	timeprecision 1ps;

	// assertion failures so far
	int fail_count = 0;

	// a strobe only inside a bus cycle
	a_stb_in_cyc: assert property (@(posedge cpu_clk) disable iff (rst)
		wb_req.stb |-> wb_req.cyc)
	else
	begin
		fail_count++;
		$error("stb high without cyc");
	end

	// request held until acknowledged
	a_req_stable: assert property (@(posedge cpu_clk) disable iff (rst)
		(wb_req.stb && !wb_rsp.ack) |=> $stable(wb_req))
	else
	begin
		fail_count++;
		$error("request changed while waiting for ack");
	end

	// halt is final until reset
	a_halt_sticky: assert property (@(posedge cpu_clk) disable iff (rst)
		halted |=> halted)
	else
	begin
		fail_count++;
		$error("halted dropped without reset");
	end

	a_halt_idle: assert property (@(posedge cpu_clk) disable iff (rst)
		halted |-> !wb_req.cyc)
	else
	begin
		fail_count++;
		$error("bus cycle while halted");
	end

endmodule

bind rv_core_top rv_core_properties u_rv_core_properties (
	.cpu_clk (cpu_clk),
	.rst     (rst),
	.wb_req  (wb_req),
	.wb_rsp  (wb_rsp),
	.halted  (halted)
);

// ==== verification/rv_core_tb.sv ====
`include "rv_defs.svh"

module rv_core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_IMM = 7'b0010011;
	localparam logic [31:0] NOP = {12'd0, 5'd0, 3'd0, 5'd0, 7'b0010011};

	logic                cpu_clk;
	logic                rst;
	rv_bus_pkg::wb_req_t wb_req;
	rv_bus_pkg::wb_rsp_t wb_rsp;
	logic [31:0]         led_word;
	logic                halted;

	logic [31:0] mem [0:4095];
	logic [31:0] t_inst [0:39][0:2];
	logic [31:0] t_op1 [0:39];
	logic [31:0] t_op2 [0:39];
	logic [31:0] t_exp [0:39];
	string       t_name [0:39];
	int          n_rows;
	int          errors;
	int          checks;
	int          cycles;
	int          cycle_limit;
	logic        busy;
	int          wait_left;
	logic        first_seen;
	logic [31:0] first_adr;

	rv_core_top u_rv_core_top (
		.cpu_clk  (cpu_clk),
		.rst      (rst),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp),
		.led_word (led_word),
		.halted   (halted)
	);

	initial
	begin
		cpu_clk = 1'b0;
		forever
			#5 cpu_clk = ~cpu_clk;
	end

	// instruction assemblers
	function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		return {f7, rs2, rs1, f3, 5'd3, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(logic [12:0] imm, logic [2:0] f3);
		return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] enc_j(logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd3, 7'b1101111};
	endfunction

	task automatic add_row(string name, logic [31:0] i0, logic [31:0] i1, logic [31:0] i2,
		logic [31:0] a, logic [31:0] b, logic [31:0] exp);
		t_name[n_rows] = name;
		t_inst[n_rows][0] = i0;
		t_inst[n_rows][1] = i1;
		t_inst[n_rows][2] = i2;
		t_op1[n_rows] = a;
		t_op2[n_rows] = b;
		t_exp[n_rows] = exp;
		n_rows++;
	endtask

	// preset x3, branch over the increment to 0x14
	task automatic add_branch(string name, logic [2:0] f3, logic [31:0] a, logic [31:0] b,
		logic tk);
		add_row(name, enc_i(12'd0, 5'd0, 3'd0, 5'd3, OPC_IMM), enc_b(13'd8, f3),
			enc_i(12'd1, 5'd3, 3'd0, 5'd3, OPC_IMM), a, b, tk ? 32'd0 : 32'd1);
	endtask

	task automatic build_table();
		logic [31:0] a;
		logic [31:0] b;
		n_rows = 0;
		a = 32'h7fff_fff0;
		b = 32'h0000_0020;
		add_row("add", enc_r(7'h00, 2, 1, 3'd0), NOP, NOP, a, b, a + b);
		a = 32'd5;
		b = 32'hffff_fff7;
		add_row("sub", enc_r(7'h20, 2, 1, 3'd0), NOP, NOP, a, b, a - b);
		add_row("sll 31", enc_r(7'h00, 2, 1, 3'd1), NOP, NOP, 32'd3, 32'd31, 32'd3 << 31);
		a = 32'h8000_0001;
		add_row("srl 0", enc_r(7'h00, 2, 1, 3'd5), NOP, NOP, a, 32'd0, a);
		a = 32'h8000_0010;
		add_row("sra", enc_r(7'h20, 2, 1, 3'd5), NOP, NOP, a, 32'd4, 32'hf800_0001);
		a = 32'hffff_ffff;
		add_row("slt", enc_r(7'h00, 2, 1, 3'd2), NOP, NOP, a, 32'd1, 32'd1);
		add_row("sltu", enc_r(7'h00, 2, 1, 3'd3), NOP, NOP, a, 32'd1, 32'd0);
		a = 32'hf0f0_1234;
		b = 32'h0ff0_4321;
		add_row("xor", enc_r(7'h00, 2, 1, 3'd4), NOP, NOP, a, b, a ^ b);
		add_row("or", enc_r(7'h00, 2, 1, 3'd6), NOP, NOP, a, b, a | b);
		add_row("and", enc_r(7'h00, 2, 1, 3'd7), NOP, NOP, a, b, a & b);
		add_row("addi", enc_i(12'hffb, 1, 3'd0, 3, OPC_IMM), NOP, NOP, 32'd3, 0, 32'd3 - 5);
		add_row("slti", enc_i(12'hfff, 1, 3'd2, 3, OPC_IMM), NOP, NOP, 32'hffff_fffe, 0, 1);
		add_row("srai 31", enc_i(12'h41f, 1, 3'd5, 3, OPC_IMM), NOP, NOP, 32'h8000_0000, 0,
			32'hffff_ffff);
		add_row("slli 0", enc_i(12'h000, 1, 3'd1, 3, OPC_IMM), NOP, NOP, a, 0, a);
		add_row("xori", enc_i(12'hfff, 1, 3'd4, 3, OPC_IMM), NOP, NOP, a, 0, ~a);
		add_row("andi", enc_i(12'h0ff, 1, 3'd7, 3, OPC_IMM), NOP, NOP, a, 0, a & 32'hff);
		a = 32'hffff_ffff;
		b = 32'd1;
		add_branch("beq taken", 3'd0, 5, 5, 5 == 5);
		add_branch("beq not", 3'd0, 5, 6, 5 == 6);
		add_branch("bne taken", 3'd1, 5, 6, 5 != 6);
		add_branch("bne not", 3'd1, 5, 5, 5 != 5);
		add_branch("blt taken", 3'd4, a, b, $signed(a) < $signed(b));
		add_branch("blt not", 3'd4, b, a, $signed(b) < $signed(a));
		add_branch("bge taken", 3'd5, b, a, $signed(b) >= $signed(a));
		add_branch("bge not", 3'd5, a, b, $signed(a) >= $signed(b));
		add_branch("bltu taken", 3'd6, b, a, b < a);
		add_branch("bltu not", 3'd6, a, b, a < b);
		add_branch("bgeu taken", 3'd7, a, b, a >= b);
		add_branch("bgeu not", 3'd7, b, a, b >= a);
		// link is the jump address plus 4 with the jump at 0x08
		// the increment at 0x0c only runs if the jump misses 0x10
		add_row("jal", enc_j(21'd8), enc_i(12'd1, 3, 3'd0, 3, OPC_IMM), NOP, 0, 0,
			32'h0000_000c);
		add_row("jalr", enc_i(12'd0, 1, 3'd0, 3, OPC_JALR), enc_i(12'd1, 3, 3'd0, 3, OPC_IMM),
			NOP, 32'h10, 0, 32'h0000_000c);
		add_row("lui", enc_u(20'habcde, 3, OPC_LUI), NOP, NOP, 0, 0, 32'habcd_e000);
		add_row("auipc", enc_u(20'h12345, 3, OPC_AUIPC), NOP, NOP, 0, 0, 32'h1234_5000 + 8);
		add_row("store reload", enc_s(12'h200, 1, 0), enc_i(12'h200, 0, 3'd2, 3, OPC_LOAD), NOP,
			32'hdead_beef, 0, 32'hdead_beef);
		// load at the RAM limit reads zero
		add_row("load above ram", enc_u(20'h4, 3, OPC_LUI), enc_i(12'd0, 3, 3'd2, 3, OPC_LOAD),
			NOP, 0, 0, 32'd0);
	endtask

	task automatic compare(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic load_program(int r);
		for (int i = 0; i < 4096; i++)
			mem[i] = {i[15:0] ^ 16'h3c5a, ~i[15:0]};
		mem[0] = enc_i(12'h100, 0, 3'd2, 1, OPC_LOAD);
		mem[1] = enc_i(12'h104, 0, 3'd2, 2, OPC_LOAD);
		mem[2] = t_inst[r][0];
		mem[3] = t_inst[r][1];
		mem[4] = t_inst[r][2];
		mem[5] = enc_u(20'h4, 4, OPC_LUI);
		mem[6] = enc_s(12'd0, 3, 4);
		mem[7] = enc_i(12'hffc, 0, 3'd0, 0, OPC_JALR);
		mem[12'h040] = t_op1[r];
		mem[12'h041] = t_op2[r];
	endtask

	task automatic run_row(int r);
		@(negedge cpu_clk);
		rst = 1'b1;
		load_program(r);
		repeat (10) @(negedge cpu_clk);
		rst = 1'b0;
		compare("wb_req.cyc", wb_req.cyc, 0);
		compare("wb_req.stb", wb_req.stb, 0);
		compare("halted", halted, 0);
		compare("led_word", led_word, 0);
		while (!halted)
			@(negedge cpu_clk);
		compare({"led_word ", t_name[r]}, led_word, t_exp[r]);
		compare("first fetch address", first_adr, `RV_RESET_PC);
		repeat (4)
		begin
			@(negedge cpu_clk);
			compare("wb_req.cyc after halt", wb_req.cyc, 0);
		end
	endtask

	// slave memory with 0 to 3 wait cycles
	always @(negedge cpu_clk)
	begin
		if (rst)
		begin
			wb_rsp <= '0;
			busy <= 1'b0;
			first_seen <= 1'b0;
		end
		else if (wb_rsp.ack)
		begin
			wb_rsp <= '0;
			busy <= 1'b0;
		end
		else if (wb_req.cyc && wb_req.stb)
		begin
			if (!busy)
			begin
				busy <= 1'b1;
				wait_left <= $urandom % 4;
				compare("wb_req.sel", wb_req.sel, 4'hf);
				if (!first_seen)
					first_adr <= wb_req.adr;
				first_seen <= 1'b1;
				if (wb_req.adr >= `RV_RAM_LIMIT)
				begin
					errors++;
					$display("bus cycle started at %h, outside RAM", wb_req.adr);
				end
			end
			else if (wait_left > 0)
				wait_left <= wait_left - 1;
			else
			begin
				if (wb_req.we)
					mem[wb_req.adr[13:2]] <= wb_req.dat;
				wb_rsp.dat <= mem[wb_req.adr[13:2]];
				wb_rsp.ack <= 1'b1;
			end
		end
	end

	always @(posedge cpu_clk)
	begin
		cycles++;
		if ((cycle_limit > 0) && (cycles > cycle_limit))
		begin
			$display("timeout after %0d cycles, core did not halt", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(32'h9898_6f16));
		rst = 1'b1;
		wb_rsp = '0;
		errors = 0;
		checks = 0;
		cycles = 0;
		cycle_limit = 0;
		busy = 1'b0;
		wait_left = 0;
		first_seen = 1'b0;
		first_adr = '0;
		build_table();
		// 8 instructions per row, 5 cycles each, worst wait x4, plus reset
		cycle_limit = n_rows * (8 * 5 * 4 + 20) + 500;
		for (int r = 0; r < n_rows; r++)
			run_row(r);
		errors += u_rv_core_top.u_rv_core_properties.fail_count;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_bus_pkg.sv
verilog/inst_decode.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/core_control.sv
verilog/rv_core_top.sv
verification/rv_core_properties.sv
verification/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_isa_pkg.sv
      - verilog/rv_bus_pkg.sv
      - verilog/inst_decode.sv
      - verilog/alu.sv
      - verilog/reg_file.sv
      - verilog/core_control.sv
      - verilog/rv_core_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/rv_core_properties.sv
      - verification/rv_core_tb.sv
